// ==== ase_emul_defines.svh ====
// ==========================================================
// Build-time sizes of the emulated host channel
// Included by the packages and by any module that sizes
// ports or arrays from these values
// ==========================================================

`ifndef ASE_EMUL_DEFINES_SVH
`define ASE_EMUL_DEFINES_SVH

// Number of AFU-side ports sharing the one host channel
`define NUM_PORTS 4

// Word address, data and AFU user extension widths
`define ADDR_WIDTH 10
`define DATA_WIDTH 32
`define USER_WIDTH 4

// Reads allowed in flight across all ports together
`define RD_TRACKER_DEPTH 6

// Depth of the host memory read pipeline, in cycles
`define MEM_RD_LATENCY 3

`endif

// ==== ase_emul_host_top.sv ====
// ==========================================================
// Emulated host channel shared by several AFU ports
// Ports arbitrate for one channel into the simulated host
// memory; read responses come back to the issuing port
// ==========================================================
`timescale 1ns/1ps
`include "ase_emul_defines.svh"

module ase_emul_host_top
    import avmm_pkg::*;
    import emul_pkg::*;
(
    input  logic                  pClk,
    input  logic                  rst,
    input  avmm_req_t             port_req [`NUM_PORTS],
    output logic [`NUM_PORTS-1:0] port_waitrequest,
    output avmm_rsp_t             port_rsp [`NUM_PORTS]
);

    logic [`NUM_PORTS-1:0] grant;
    logic                  rd_credit_ret;
    avmm_req_t             chan_req;
    chan_tag_t             chan_tag;
    avmm_rsp_t             chan_rsp;
    chan_tag_t             chan_rsp_tag;

    // ==========================================================
    // Request path
    // ==========================================================

    avmm_port_mux_ctrl u_ctrl (
        .pClk             (pClk),
        .rst              (rst),
        .port_req         (port_req),
        .rd_credit_ret    (rd_credit_ret),
        .grant            (grant),
        .port_waitrequest (port_waitrequest)
    );

    avmm_req_mux u_req_mux (
        .pClk     (pClk),
        .rst      (rst),
        .port_req (port_req),
        .grant    (grant),
        .chan_req (chan_req),
        .chan_tag (chan_tag)
    );

    // Host memory and the response path back to the ports
    sim_host_mem u_mem (
        .pClk         (pClk),
        .rst          (rst),
        .chan_req     (chan_req),
        .chan_tag     (chan_tag),
        .chan_rsp     (chan_rsp),
        .chan_rsp_tag (chan_rsp_tag)
    );

    avmm_rsp_router u_rsp_router (
        .pClk          (pClk),
        .rst           (rst),
        .chan_rsp      (chan_rsp),
        .chan_rsp_tag  (chan_rsp_tag),
        .port_rsp      (port_rsp),
        .rd_credit_ret (rd_credit_ret)
    );

endmodule

// ==== avmm_pkg.sv ====
// ==========================================================
// Avalon-style transfer types shared by the AFU ports and
// the emulated host channel
// Import with a wildcard in the module header
// ==========================================================

`include "ase_emul_defines.svh"

package avmm_pkg;

    // Word address, data word and AFU user extension
    typedef logic [`ADDR_WIDTH-1:0] mem_addr_t;
    typedef logic [`DATA_WIDTH-1:0] mem_data_t;
    typedef logic [`USER_WIDTH-1:0] mem_user_t;

    // One request beat, driven by a port or by the channel mux
    // Read and write are strobes and are never high together
    typedef struct packed {
        logic      read;
        logic      write;
        mem_addr_t address;
        mem_data_t writedata;
        mem_user_t user;
    } avmm_req_t;

    // One response beat, valid only in the cycle of readdatavalid
    typedef struct packed {
        logic      readdatavalid;
        mem_data_t readdata;
        mem_user_t user;
    } avmm_rsp_t;

endpackage

// ==== avmm_port_mux_ctrl.sv ====
// ==========================================================
// Round-robin arbiter for the emulated AFU ports
// Grants at most one port per cycle, holds reads back when
// the shared read credits run out, drives waitrequest
// ==========================================================
`timescale 1ns/1ps
`include "ase_emul_defines.svh"

module avmm_port_mux_ctrl
    import avmm_pkg::*;
    import emul_pkg::*;
(
    input  logic                  pClk,
    input  logic                  rst,
    input  avmm_req_t             port_req [`NUM_PORTS],
    input  logic                  rd_credit_ret,
    output logic [`NUM_PORTS-1:0] grant,
    output logic [`NUM_PORTS-1:0] port_waitrequest
);

    arb_state_e              arb_state;
    arb_state_e              arb_next;
    port_idx_t               last_idx;
    port_idx_t               base_idx;
    port_idx_t               cand_idx;
    port_idx_t               grant_idx;
    logic                    found;
    logic                    rd_grant;
    logic [`NUM_PORTS-1:0]   eligible;
    logic [`NUM_PORTS-1:0]   rd_vec;
    credit_cnt_t             credit_cnt;

    // Writes always compete, reads only while a credit is left
    always_comb
    begin
        for (int i = 0; i < `NUM_PORTS; i++)
        begin
            rd_vec[i]   = port_req[i].read;
            eligible[i] = port_req[i].write | (port_req[i].read & (credit_cnt != '0));
        end
    end

    // Search starts one past the last winner; port 0 right after reset
    // Index wraps by truncation since the port count is a power of two
    always_comb
    begin
        base_idx  = (arb_state == ARB_GRANT) ? port_idx_t'(last_idx + 1'b1) : '0;
        grant     = '0;
        grant_idx = '0;
        found     = 1'b0;
        cand_idx  = '0;
        for (int off = 0; off < `NUM_PORTS; off++)
        begin
            cand_idx = port_idx_t'(base_idx + off);
            if (!found && eligible[cand_idx])
            begin
                grant[cand_idx] = 1'b1;
                grant_idx       = cand_idx;
                found           = 1'b1;
            end
        end
    end

    // Every port that was not picked this cycle is stalled
    assign port_waitrequest = ~grant;
    assign rd_grant         = |(grant & rd_vec);

    always_comb
    begin
        case (arb_state)
            ARB_IDLE:  arb_next = found ? ARB_GRANT : ARB_IDLE;
            ARB_GRANT: arb_next = ARB_GRANT;
            default:   arb_next = ARB_IDLE;
        endcase
    end

    always_ff @(posedge pClk)
    begin
        if (rst)
        begin
            arb_state <= ARB_IDLE;
            last_idx  <= '0;
        end
        else
        begin
            arb_state <= arb_next;
            if (found)
                last_idx <= grant_idx;
        end
    end

    // ==========================================================
    // Read credits
    // ==========================================================

    // A granted read takes a credit, a routed response returns one
    always_ff @(posedge pClk)
    begin
        if (rst)
            credit_cnt <= credit_cnt_t'(`RD_TRACKER_DEPTH);
        else if (rd_grant && !rd_credit_ret)
            credit_cnt <= credit_cnt - 1'b1;
        else if (!rd_grant && rd_credit_ret)
            credit_cnt <= credit_cnt + 1'b1;
    end

    a_grant_onehot: assert property (@(posedge pClk) disable iff (rst) $onehot0(grant));

    // Holds only if the router returns exactly one credit per read
    a_credit_bound: assert property (@(posedge pClk) disable iff (rst)
        credit_cnt <= `RD_TRACKER_DEPTH);

endmodule

// ==== avmm_req_mux.sv ====
// ==========================================================
// Request side of the shared host channel
// Registers the granted port's request onto the channel and
// tags it with the source port and the AFU user bits
// ==========================================================
`timescale 1ns/1ps
`include "ase_emul_defines.svh"

module avmm_req_mux
    import avmm_pkg::*;
    import emul_pkg::*;
(
    input  logic                  pClk,
    input  logic                  rst,
    input  avmm_req_t             port_req [`NUM_PORTS],
    input  logic [`NUM_PORTS-1:0] grant,
    output avmm_req_t             chan_req,
    output chan_tag_t             chan_tag
);

    avmm_req_t sel_req;
    port_idx_t sel_idx;

    // Grant is one-hot or zero, so the default leaves read and
    // write low in a cycle with no winner
    always_comb
    begin
        sel_req = '0;
        sel_idx = '0;
        for (int i = 0; i < `NUM_PORTS; i++)
        begin
            if (grant[i])
            begin
                sel_req = port_req[i];
                sel_idx = port_idx_t'(i);
            end
        end
    end

    // The host side has no user field, so it moves into the tag
    always_ff @(posedge pClk)
    begin
        chan_req      <= sel_req;
        chan_req.user <= '0;
        chan_tag.src  <= sel_idx;
        chan_tag.user <= sel_req.user;
        if (rst)
        begin
            chan_req.read  <= 1'b0;
            chan_req.write <= 1'b0;
        end
    end

    // A port driving both strobes at once breaks the Avalon rule
    a_rd_wr_excl: assert property (@(posedge pClk) disable iff (rst)
        !(chan_req.read && chan_req.write));

endmodule

// ==== avmm_rsp_router.sv ====
// ==========================================================
// Response side of the shared host channel
// Steers each read response to the port named in its tag,
// restores the user bits and returns one read credit
// ==========================================================
`timescale 1ns/1ps
`include "ase_emul_defines.svh"

module avmm_rsp_router
    import avmm_pkg::*;
    import emul_pkg::*;
(
    input  logic      pClk,
    input  logic      rst,
    input  avmm_rsp_t chan_rsp,
    input  chan_tag_t chan_rsp_tag,
    output avmm_rsp_t port_rsp [`NUM_PORTS],
    output logic      rd_credit_ret
);

    logic [`NUM_PORTS-1:0] hit;
    logic [`NUM_PORTS-1:0] rsp_vld;

    // Decode the owning port of the beat on the channel
    always_comb
    begin
        for (int i = 0; i < `NUM_PORTS; i++)
        begin
            hit[i]     = chan_rsp.readdatavalid && (chan_rsp_tag.src == port_idx_t'(i));
            rsp_vld[i] = port_rsp[i].readdatavalid;
        end
    end

    // Payload only loads into the port that owns the beat
    always_ff @(posedge pClk)
    begin
        for (int i = 0; i < `NUM_PORTS; i++)
        begin
            port_rsp[i].readdatavalid <= rst ? 1'b0 : hit[i];
            if (hit[i])
            begin
                port_rsp[i].readdata <= chan_rsp.readdata;
                port_rsp[i].user     <= chan_rsp_tag.user;
            end
        end
        rd_credit_ret <= rst ? 1'b0 : chan_rsp.readdatavalid;
    end

    // The channel carries one beat per cycle, so one port at most
    a_rsp_onehot: assert property (@(posedge pClk) disable iff (rst) $onehot0(rsp_vld));

endmodule

// ==== build.f ====
+incdir+.
avmm_pkg.sv
emul_pkg.sv
avmm_port_mux_ctrl.sv
avmm_req_mux.sv
sim_host_mem.sv
avmm_rsp_router.sv
ase_emul_host_top.sv
tb_ase_emul_host.sv

// ==== emul_pkg.sv ====
// ==========================================================
// Bookkeeping types of the host channel emulation
// Covers port indices, the routing tag and the arbiter FSM
// ==========================================================

`include "ase_emul_defines.svh"

package emul_pkg;

    import avmm_pkg::*;

    localparam int PORT_IDX_WIDTH = $clog2(`NUM_PORTS);
    localparam int CREDIT_WIDTH   = $clog2(`RD_TRACKER_DEPTH + 1);

    typedef logic [PORT_IDX_WIDTH-1:0] port_idx_t;

    // Read credits left, from zero up to the tracker depth
    typedef logic [CREDIT_WIDTH-1:0] credit_cnt_t;

    // Rides alongside each shared-channel beat so that a
    // response can find its way back to the issuing port
    typedef struct packed {
        port_idx_t src;
        mem_user_t user;
    } chan_tag_t;

    // IDLE until the first grant, then the pointer is live
    typedef enum logic [0:0] {ARB_IDLE, ARB_GRANT} arb_state_e;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Compile the testbench with Verilator, run it and decide the
# result from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module tb_ase_emul_host -Mdir "$OBJ" -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ/tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* TEST PASSED \*\*\*$' "$LOG"; then
    exit 0
fi
exit 1

// ==== sim_host_mem.sv ====
// ==========================================================
// Simulated host memory behind the shared channel
// Writes land in one cycle; reads return after a fixed
// pipelined latency with the request tag carried along
// ==========================================================
`timescale 1ns/1ps
`include "ase_emul_defines.svh"

module sim_host_mem
    import avmm_pkg::*;
    import emul_pkg::*;
(
    input  logic      pClk,
    input  logic      rst,
    input  avmm_req_t chan_req,
    input  chan_tag_t chan_tag,
    output avmm_rsp_t chan_rsp,
    output chan_tag_t chan_rsp_tag
);

    localparam int LAT = `MEM_RD_LATENCY;

    mem_data_t mem [2**`ADDR_WIDTH];

    // One entry per pipeline stage, stage 0 is the array read
    logic      rd_vld_q  [LAT];
    mem_data_t rd_data_q [LAT];
    chan_tag_t rd_tag_q  [LAT];

    always_ff @(posedge pClk)
    begin
        if (chan_req.write)
            mem[chan_req.address] <= chan_req.writedata;
    end

    // Only one beat per cycle reaches the channel, so a read
    // never collides with a write to the same word
    always_ff @(posedge pClk)
    begin
        rd_data_q[0] <= mem[chan_req.address];
        rd_tag_q[0]  <= chan_tag;
        for (int s = 1; s < LAT; s++)
        begin
            rd_data_q[s] <= rd_data_q[s-1];
            rd_tag_q[s]  <= rd_tag_q[s-1];
        end
    end

    // Read valid shifts down the pipeline beside its data and tag
    always_ff @(posedge pClk)
    begin
        if (rst)
        begin
            for (int s = 0; s < LAT; s++)
                rd_vld_q[s] <= 1'b0;
        end
        else
        begin
            rd_vld_q[0] <= chan_req.read;
            for (int s = 1; s < LAT; s++)
                rd_vld_q[s] <= rd_vld_q[s-1];
        end
    end

    // The host returns no user bits; the tag holds them instead
    assign chan_rsp.readdatavalid = rd_vld_q[LAT-1];
    assign chan_rsp.readdata      = rd_data_q[LAT-1];
    assign chan_rsp.user          = '0;
    assign chan_rsp_tag           = rd_tag_q[LAT-1];

endmodule

// ==== tb_ase_emul_host.sv ====
// ==========================================================
// Testbench for the emulated host channel
// Drives the four AFU ports, mirrors every accepted write in
// a shadow memory and queues the expected read responses per
// port; concurrent assertions on the falling edge check them
// ==========================================================
`timescale 1ns/1ps
`include "ase_emul_defines.svh"

module tb_ase_emul_host
    import avmm_pkg::*;
    import emul_pkg::*;
();

    // Mux register, memory pipeline and router register
    localparam int RD_LATENCY      = `MEM_RD_LATENCY + 2;
    localparam int TEST_COUNT      = 6;
    localparam int CYCLES_PER_TEST = 500;
    localparam int CYCLE_LIMIT     = TEST_COUNT * CYCLES_PER_TEST;

    typedef struct packed {
        mem_data_t   data;
        mem_user_t   user;
        int unsigned due;
    } exp_rd_t;

    logic                  pClk;
    logic                  rst;
    avmm_req_t             port_req [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] port_waitrequest;
    avmm_rsp_t             port_rsp [`NUM_PORTS];

    mem_data_t             shadow [2**`ADDR_WIDTH];
    exp_rd_t               exp_q [`NUM_PORTS][$];
    exp_rd_t               head [`NUM_PORTS];
    logic [`NUM_PORTS-1:0] head_vld = '0;
    logic [`NUM_PORTS-1:0] acc;
    int unsigned           cyc = 0;
    int                    outstanding = 0;
    int                    wait_grants [`NUM_PORTS] = '{default: 0};
    logic                  fair_en;
    logic                  bp_en;
    int                    bp_acc = 0;
    int                    bp_rsp = 0;
    int                    err_cnt = 0;
    int                    rd_checked = 0;
    int                    tests_run;

    always #2 pClk = ~pClk;

    ase_emul_host_top uut (
        .pClk             (pClk),
        .rst              (rst),
        .port_req         (port_req),
        .port_waitrequest (port_waitrequest),
        .port_rsp         (port_rsp)
    );

    // A port's request is taken at the next rising edge
    always_comb
    begin
        for (int p = 0; p < `NUM_PORTS; p++)
            acc[p] = (port_req[p].read | port_req[p].write) & ~port_waitrequest[p];
    end

    // Between edges cyc holds the index of the coming rising edge
    always @(posedge pClk)
    begin
        cyc <= cyc + 1;
        if (cyc >= CYCLE_LIMIT)
        begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ==========================================================
    // Scoreboard, sampled mid-cycle where all signals are stable
    // ==========================================================

    always @(negedge pClk)
    begin
        exp_rd_t ent;
        if (!rst)
        begin
            for (int p = 0; p < `NUM_PORTS; p++)
            begin
                // Retire the oldest read first, then queue a new one
                if (port_rsp[p].readdatavalid && exp_q[p].size() > 0)
                begin
                    ent = exp_q[p].pop_front();
                    outstanding = outstanding - 1;
                    rd_checked  = rd_checked + 1;
                    if (bp_en)
                        bp_rsp = bp_rsp + 1;
                end
                if (acc[p] && port_req[p].write)
                    shadow[port_req[p].address] = port_req[p].writedata;
                if (acc[p] && port_req[p].read)
                begin
                    ent.data = shadow[port_req[p].address];
                    ent.user = port_req[p].user;
                    ent.due  = cyc + RD_LATENCY;
                    exp_q[p].push_back(ent);
                    outstanding = outstanding + 1;
                    if (bp_en)
                        bp_acc = bp_acc + 1;
                end
                // Grants seen by a port still waiting for its own turn
                if (!fair_en || !(port_req[p].read || port_req[p].write) || acc[p])
                    wait_grants[p] = 0;
                else if (|acc)
                    wait_grants[p] = wait_grants[p] + 1;
                head_vld[p] = (exp_q[p].size() > 0);
                if (head_vld[p])
                    head[p] = exp_q[p][0];
            end
        end
    end

    // ==========================================================
    // Checks
    // ==========================================================

    for (genvar g = 0; g < `NUM_PORTS; g++)
    begin : g_port_chk
        a_rsp_owned: assert property (@(negedge pClk) disable iff (rst)
            port_rsp[g].readdatavalid |-> head_vld[g])
        else
        begin
            err_cnt++;
            $display("Port %0d got a read response that it never asked for", g);
        end

        a_rsp_data: assert property (@(negedge pClk) disable iff (rst)
            port_rsp[g].readdatavalid && head_vld[g] |-> port_rsp[g].readdata == head[g].data)
        else
        begin
            err_cnt++;
            $display("[ERROR] port_rsp[%0d].readdata = 0x%h, expected 0x%h", g,
                     $sampled(port_rsp[g].readdata), $sampled(head[g].data));
        end

        a_rsp_user: assert property (@(negedge pClk) disable iff (rst)
            port_rsp[g].readdatavalid && head_vld[g] |-> port_rsp[g].user == head[g].user)
        else
        begin
            err_cnt++;
            $display("[ERROR] port_rsp[%0d].user = 0x%h, expected 0x%h", g,
                     $sampled(port_rsp[g].user), $sampled(head[g].user));
        end

        a_rsp_early: assert property (@(negedge pClk) disable iff (rst)
            port_rsp[g].readdatavalid && head_vld[g] |-> cyc == head[g].due)
        else
        begin
            err_cnt++;
            $display("Port %0d response came at cycle %0d, it was due at cycle %0d", g,
                     $sampled(cyc), $sampled(head[g].due));
        end

        a_rsp_late: assert property (@(negedge pClk) disable iff (rst)
            head_vld[g] && cyc == head[g].due |-> port_rsp[g].readdatavalid)
        else
        begin
            err_cnt++;
            $display("Port %0d response missing at its due cycle %0d", g, $sampled(cyc));
        end

        a_fair: assert property (@(negedge pClk) disable iff (rst)
            fair_en |-> wait_grants[g] < `NUM_PORTS)
        else
        begin
            err_cnt++;
            $display("Port %0d passed over for %0d grants in a row", g, $sampled(wait_grants[g]));
        end
    end

    a_one_accept: assert property (@(negedge pClk) disable iff (rst) $onehot0(acc))
    else
    begin
        err_cnt++;
        $display("More than one port was accepted in the same cycle");
    end

    a_outstanding: assert property (@(negedge pClk) disable iff (rst)
        outstanding <= `RD_TRACKER_DEPTH)
    else
    begin
        err_cnt++;
        $display("%0d reads in flight, above the tracker depth", $sampled(outstanding));
    end

    a_credit_wait: assert property (@(negedge pClk) disable iff (rst)
        bp_en && bp_acc > `RD_TRACKER_DEPTH |-> bp_rsp > 0)
    else
    begin
        err_cnt++;
        $display("A read beyond the tracker depth was taken before any response");
    end

    // ==========================================================
    // Stimulus
    // ==========================================================

    // Each port reads and writes its own window of the memory
    function automatic mem_addr_t port_base(input int p);
        return mem_addr_t'(256 + p * 64);
    endfunction

    // Called a half ns after a rising edge, returns likewise
    task automatic drive_xfer(input int p, input logic wr, input mem_addr_t addr,
                              input mem_data_t data, input mem_user_t user);
        logic done;
        port_req[p].read      = ~wr;
        port_req[p].write     = wr;
        port_req[p].address   = addr;
        port_req[p].writedata = data;
        port_req[p].user      = user;
        done = 1'b0;
        while (!done)
        begin
            @(negedge pClk);
            done = ~port_waitrequest[p];
            @(posedge pClk);
            #0.5;
        end
        port_req[p].read  = 1'b0;
        port_req[p].write = 1'b0;
    endtask

    task automatic write_burst(input int p, input int n, input mem_addr_t base);
        for (int i = 0; i < n; i++)
            drive_xfer(p, 1'b1, mem_addr_t'(base + i), $urandom(), mem_user_t'($urandom()));
    endtask

    task automatic read_burst(input int p, input int n, input mem_addr_t base);
        for (int i = 0; i < n; i++)
            drive_xfer(p, 1'b0, mem_addr_t'(base + i), '0, mem_user_t'($urandom()));
    endtask

    // Wait until every queued read has been answered
    task automatic drain();
        while (outstanding != 0)
            @(negedge pClk);
        @(posedge pClk);
        #0.5;
    endtask

    task automatic close_test(input string name, input int err_before);
        tests_run = tests_run + 1;
        $display("Test %0d %-20s %s", tests_run, name,
                 (err_cnt == err_before) ? "ok" : "with errors");
    endtask

    initial
    begin
        int        e0;
        mem_addr_t addr;
        pClk      = 1'b0;
        rst       = 1'b1;
        fair_en   = 1'b0;
        bp_en     = 1'b0;
        tests_run = 0;
        for (int p = 0; p < `NUM_PORTS; p++)
            port_req[p] = '0;
        void'($urandom(6717));
        repeat (3) @(posedge pClk);
        #0.5;
        rst = 1'b0;

        e0   = err_cnt;
        addr = mem_addr_t'($urandom());
        drive_xfer(0, 1'b1, addr, $urandom(), '0);
        drive_xfer(0, 1'b0, addr, '0, mem_user_t'($urandom()));
        drain();
        close_test("read_after_write", e0);

        e0 = err_cnt;
        for (int i = 0; i < 3; i++)
        begin
            addr = mem_addr_t'($urandom());
            drive_xfer(1, 1'b1, addr, $urandom(), '0);
            drive_xfer(1, 1'b0, addr, '0, mem_user_t'($urandom()));
        end
        drain();
        close_test("user_field", e0);

        e0 = err_cnt;
        fork
            write_burst(0, 4, port_base(0));
            write_burst(1, 4, port_base(1));
            write_burst(2, 4, port_base(2));
            write_burst(3, 4, port_base(3));
        join
        fork
            read_burst(0, 4, port_base(0));
            read_burst(1, 4, port_base(1));
            read_burst(2, 4, port_base(2));
            read_burst(3, 4, port_base(3));
        join
        drain();
        close_test("concurrent_routing", e0);

        // Back-to-back reads keep several in flight at once
        e0 = err_cnt;
        fork
            read_burst(2, 4, port_base(2));
            read_burst(3, 4, port_base(3));
            write_burst(0, 3, port_base(0) + mem_addr_t'(32));
        join
        drain();
        close_test("read_latency", e0);

        e0      = err_cnt;
        fair_en = 1'b1;
        fork
            write_burst(0, 8, port_base(0));
            write_burst(1, 8, port_base(1));
            write_burst(2, 8, port_base(2));
            write_burst(3, 8, port_base(3));
        join
        fair_en = 1'b0;
        drain();
        close_test("round_robin", e0);

        e0    = err_cnt;
        bp_en = 1'b1;
        read_burst(0, 7, port_base(0));
        drain();
        bp_en = 1'b0;
        close_test("credit_backpressure", e0);

        $display("Tests run %0d, reads checked %0d, errors %0d", tests_run, rd_checked, err_cnt);
        if (err_cnt == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
